// File: bench/board_properties.sv
`timescale 1ns/1ps

module board_properties (
    input logic clock_in,
    input logic reset_in,
    input logic ack,
    input logic cyc,
    input logic stb,
    input logic line,
    input logic busy
);

    ////////////////////////////////////////
    // Wishbone slave side
    ////////////////////////////////////////

    // Single-cycle ack
    ack_one_cycle: assert property (
        @(posedge clock_in) disable iff (reset_in) ack |=> !ack
    ) else $error("ack lasted more than one cycle");

    // Ack only inside an open transfer
    ack_in_cycle: assert property (
        @(posedge clock_in) disable iff (reset_in) ack |-> (cyc && stb)
    ) else $error("ack raised without cyc and stb");

    ////////////////////////////////////////
    // Serial transmitter
    ////////////////////////////////////////

    // Idle line stays high
    line_idle_high: assert property (
        @(posedge clock_in) disable iff (reset_in) !busy |-> line
    ) else $error("serial line low while transmitter idle");

endmodule

// Bus checks on the game controller, serial side tied off
bind game_fsm board_properties game_props (
    .clock_in (clock_in),
    .reset_in (reset_in),
    .ack      (wb_rsp.ack),
    .cyc      (wb_req.cyc),
    .stb      (wb_req.stb),
    .line     (1'b1),
    .busy     (1'b0)
);

// Line checks on the transmitter, bus side tied off
bind board_link_tx board_properties link_props (
    .clock_in (clock_in),
    .reset_in (reset_in),
    .ack      (1'b0),
    .cyc      (1'b0),
    .stb      (1'b0),
    .line     (line),
    .busy     (busy)
);

// File: bench/board_tb.sv
`timescale 1ns/1ps

module board_tb;

    logic               clock_in;
    logic               reset_in;
    board_pkg::wb_req_t wb_req;
    board_pkg::wb_rsp_t wb_rsp;
    logic               button;
    logic               follow;
    logic               link_rx;
    logic               link_tx;
    // Switch that loops the transmitter back to the receiver
    logic               loopback;

    // Reference model of the game
    board_pkg::board_t model_board;
    logic              model_player;
    logic [7:0]        model_illegal;

    logic [31:0] rand_state;
    int          error_count;
    int          timeout_count;

    // Idle high when the loop is open
    assign link_rx = loopback ? link_tx : 1'b1;

    board_top dut0 (
        .clock_in (clock_in),
        .reset_in (reset_in),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .button   (button),
        .follow   (follow),
        .link_rx  (link_rx),
        .link_tx  (link_tx)
    );

    // 10 ns clock
    initial begin
        clock_in = 1'b0;
        forever #5 clock_in = ~clock_in;
    end

    ////////////////////////////////////////
    // Helpers and reference model
    ////////////////////////////////////////

    task automatic report_mismatch(input string name, input board_pkg::board_t got,
                                   input board_pkg::board_t expected);
        $display("Error at time %0t: %s got %0h expected %0h", $time, name, got, expected);
        error_count++;
    endtask

    // LCG step
    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic int random_cell();
        logic [31:0] r;
        r = next_random();
        return int'(r[31:16]) % board_pkg::BOARD_CELLS;
    endfunction

    // Effect of one bus write on the model
    function automatic void model_write(input int adr);
        if (adr < board_pkg::BOARD_CELLS
                && model_board[2*adr +: 2] == board_pkg::CELL_EMPTY) begin
            model_board[2*adr +: 2] = model_player ? board_pkg::CELL_O : board_pkg::CELL_X;
            model_player = !model_player;
        end else if (adr == int'(board_pkg::ADR_CLEAR)) begin
            model_board = '0;
            model_player = 1'b0;
        end else if (model_illegal != 8'hFF) begin
            model_illegal = model_illegal + 8'd1;
        end
    endfunction

    // One Wishbone classic transfer held until ack
    task automatic bus_transfer(input logic we, input board_pkg::wb_addr_t adr,
                                output board_pkg::wb_data_t data);
        board_pkg::wb_req_t req;
        logic [31:0]        r;
        int                 waited;
        r = next_random();
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = we;
        req.adr = adr;
        // Write data is a don't care for the slave
        req.dat_w = r[15:0];
        @(posedge clock_in);
        wb_req <= req;
        waited = 0;
        @(negedge clock_in);
        while (!wb_rsp.ack && waited < 32) begin
            @(negedge clock_in);
            waited++;
        end
        if (!wb_rsp.ack) begin
            $display("Timeout waiting for ack at bus address %0h", adr);
            timeout_count++;
        end
        data = wb_rsp.dat_r;
        @(posedge clock_in);
        wb_req <= '0;
    endtask

    task automatic play_move(input int adr);
        board_pkg::wb_data_t unused;
        bus_transfer(1'b1, board_pkg::wb_addr_t'(adr), unused);
        model_write(adr);
    endtask

    task automatic check_cell(input int idx);
        board_pkg::wb_data_t data;
        board_pkg::wb_data_t expected;
        bus_transfer(1'b0, board_pkg::wb_addr_t'(idx), data);
        expected = {14'd0, model_board[2*idx +: 2]};
        if (data !== expected) begin
            report_mismatch($sformatf("dat_r of cell %0d", idx), data, expected);
        end
    endtask

    task automatic check_status();
        board_pkg::wb_data_t data;
        board_pkg::wb_data_t expected;
        bus_transfer(1'b0, board_pkg::ADR_STATUS, data);
        expected = {model_illegal, 7'd0, model_player};
        if (data !== expected) begin
            report_mismatch("dat_r of status", data, expected);
        end
    endtask

    task automatic check_board();
        for (int i = 0; i < board_pkg::BOARD_CELLS; i++) begin
            check_cell(i);
        end
        check_status();
    endtask

    task automatic check_line_idle(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clock_in);
            if (link_tx !== 1'b1) begin
                report_mismatch("link_tx while idle", link_tx, 1'b1);
                return;
            end
        end
    endtask

    ////////////////////////////////////////
    // Serial frame handling
    ////////////////////////////////////////

    // Samples link_tx in the middle of each bit
    task automatic capture_frame(output board_pkg::board_t data, output logic start_bit,
                                 output logic stop_bit);
        int waited;
        data = '0;
        start_bit = 1'b1;
        stop_bit = 1'b0;
        waited = 0;
        @(negedge clock_in);
        while (link_tx && waited < 200) begin
            @(negedge clock_in);
            waited++;
        end
        if (link_tx) begin
            $display("Timeout waiting for a start bit on link_tx");
            timeout_count++;
            return;
        end
        // First low sample is the first cycle of the start bit
        repeat (board_pkg::BIT_CYCLES / 2) @(negedge clock_in);
        start_bit = link_tx;
        for (int k = 0; k < board_pkg::BOARD_BITS; k++) begin
            repeat (board_pkg::BIT_CYCLES) @(negedge clock_in);
            data[k] = link_tx;
        end
        repeat (board_pkg::BIT_CYCLES) @(negedge clock_in);
        stop_bit = link_tx;
    endtask

    // Moves made while the snapshot is on the wire
    task automatic make_moves_in_frame(input int count);
        int waited;
        waited = 0;
        @(negedge clock_in);
        while (link_tx && waited < 200) begin
            @(negedge clock_in);
            waited++;
        end
        if (link_tx) begin
            $display("Timeout waiting for the frame before moves");
            timeout_count++;
            return;
        end
        repeat (count) begin
            play_move(random_cell());
        end
    endtask

    // Press and decode and optionally receive before comparing the board
    task automatic run_frame(input logic loop_on, input logic follow_on, input int moves);
        board_pkg::board_t snapshot;
        board_pkg::board_t decoded;
        logic              start_bit;
        logic              stop_bit;
        int                waited;
        snapshot = model_board;
        @(posedge clock_in);
        loopback <= loop_on;
        follow <= follow_on;
        button <= 1'b1;
        fork
            capture_frame(decoded, start_bit, stop_bit);
            begin
                repeat (board_pkg::DEBOUNCE_CYCLES + 24) @(posedge clock_in);
                button <= 1'b0;
            end
            make_moves_in_frame(moves);
        join
        if (start_bit !== 1'b0) begin
            report_mismatch("link_tx start bit", start_bit, 1'b0);
        end
        if (stop_bit !== 1'b1) begin
            report_mismatch("link_tx stop bit", stop_bit, 1'b1);
        end
        if (decoded !== snapshot) begin
            report_mismatch("link_tx frame data", decoded, snapshot);
        end
        if (loop_on) begin
            waited = 0;
            @(negedge clock_in);
            while (!dut0.rx_valid && waited < 64) begin
                @(negedge clock_in);
                waited++;
            end
            if (!dut0.rx_valid) begin
                $display("Timeout waiting for rx_valid after the frame");
                timeout_count++;
            end else if (follow_on) begin
                // Received snapshot replaces the local board
                model_board = snapshot;
            end
        end
        check_board();
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        board_pkg::wb_data_t data;
        int                  count;
        int                  idx;
        reset_in = 1'b1;
        wb_req = '0;
        button = 1'b0;
        follow = 1'b0;
        loopback = 1'b0;
        model_board = '0;
        model_player = 1'b0;
        model_illegal = 8'd0;
        rand_state = 32'h6c21_e5db;
        error_count = 0;
        timeout_count = 0;
        repeat (16) @(posedge clock_in);
        reset_in <= 1'b0;
        @(negedge clock_in);
        if (link_tx !== 1'b1) begin
            report_mismatch("link_tx after reset", link_tx, 1'b1);
        end
        if (wb_rsp.ack !== 1'b0) begin
            report_mismatch("ack after reset", wb_rsp.ack, 1'b0);
        end
        check_board();

        // Random legal and occupied moves
        for (int n = 0; n < 200; n++) begin
            idx = random_cell();
            play_move(idx);
            check_cell(idx);
            check_status();
        end
        check_board();

        // Writes outside the board and then onto occupied cells
        for (int adr = 81; adr <= 253; adr++) begin
            play_move(adr);
            check_status();
        end
        count = 0;
        for (int i = 0; i < board_pkg::BOARD_CELLS; i++) begin
            if (count < 20 && model_board[2*i +: 2] != board_pkg::CELL_EMPTY) begin
                play_move(i);
                count++;
            end
        end
        check_board();
        // Unmapped read
        bus_transfer(1'b0, 8'h90, data);
        if (data !== 16'd0) begin
            report_mismatch("dat_r of unmapped address", data, 16'd0);
        end

        // Clear keeps the illegal count
        play_move(int'(board_pkg::ADR_CLEAR));
        check_board();
        repeat (12) begin
            play_move(random_cell());
        end

        // Short press is filtered
        @(posedge clock_in);
        button <= 1'b1;
        repeat (board_pkg::DEBOUNCE_CYCLES - 8) @(posedge clock_in);
        button <= 1'b0;
        check_line_idle(100);

        // Long press gives exactly one frame
        run_frame(1'b0, 1'b0, 0);
        check_line_idle(300);

        // With follow on the board becomes the snapshot
        run_frame(1'b1, 1'b1, 6);

        // With follow off the local moves stay
        run_frame(1'b1, 1'b0, 6);

        $display("Mismatches: %0d  Timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
hw/board_pkg.sv
hw/debounce.sv
hw/bit_timer.sv
hw/board_link_tx.sv
hw/board_link_rx.sv
hw/game_fsm.sv
hw/board_top.sv
bench/board_properties.sv
bench/board_tb.sv

// File: hw/bit_timer.sv
`timescale 1ns/1ps

module bit_timer (
    input  logic       clock_in,
    input  logic       reset_in,
    input  logic       start,
    output logic       active,
    output logic       mid,
    output logic       bit_end,
    output logic [7:0] bit_index
);

    // Position inside the current bit period
    logic [$clog2(board_pkg::BIT_CYCLES)-1:0] cycle_cnt;

    // Strobes only while a frame runs
    assign mid = active && (cycle_cnt == board_pkg::BIT_CYCLES / 2 - 1);
    assign bit_end = active && (cycle_cnt == board_pkg::BIT_CYCLES - 1);

    always_ff @(posedge clock_in) begin
        if (reset_in) begin
            active <= 1'b0;
            cycle_cnt <= '0;
            bit_index <= '0;
        end else if (start) begin
            // Restart from bit 0
            active <= 1'b1;
            cycle_cnt <= '0;
            bit_index <= '0;
        end else if (active) begin
            cycle_cnt <= cycle_cnt + 1'b1;
            if (bit_end) begin
                cycle_cnt <= '0;
                // Last bit of the frame done
                if (bit_index == 8'(board_pkg::FRAME_BITS - 1)) begin
                    active <= 1'b0;
                end else begin
                    bit_index <= bit_index + 8'd1;
                end
            end
        end
    end

endmodule

// File: hw/board_link_rx.sv
`timescale 1ns/1ps

module board_link_rx (
    input  logic              clock_in,
    input  logic              reset_in,
    input  logic              line,
    output logic              rx_valid,
    output board_pkg::board_t rx_board
);

    // Two-flop synchronizer plus edge history
    logic sync1;
    logic sync2;
    logic line_prev;

    // Frame in progress
    logic receiving;
    logic start_edge;

    logic       timer_mid;
    logic [7:0] bit_index;

    // Incoming data bits, filled from the top
    board_pkg::board_t rx_shift;

    // Falling edge while idle marks a start bit
    assign start_edge = !receiving && line_prev && !sync2;

    bit_timer rx_timer (
        .clock_in  (clock_in),
        .reset_in  (reset_in),
        .start     (start_edge),
        .active    (),
        .mid       (timer_mid),
        .bit_end   (),
        .bit_index (bit_index)
    );

    ////////////////////////////////////////
    // Control path
    ////////////////////////////////////////

    always_ff @(posedge clock_in) begin
        if (reset_in) begin
            sync1 <= 1'b1;
            sync2 <= 1'b1;
            line_prev <= 1'b1;
            receiving <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            sync1 <= line;
            sync2 <= sync1;
            line_prev <= sync2;
            rx_valid <= 1'b0;
            if (start_edge) begin
                receiving <= 1'b1;
            end else if (receiving && timer_mid) begin
                // Glitch, start bit not held low
                if (bit_index == 8'd0 && sync2) begin
                    receiving <= 1'b0;
                end
                // Stop bit ends the frame early so the next edge is seen
                if (bit_index == 8'(board_pkg::FRAME_BITS - 1)) begin
                    receiving <= 1'b0;
                    rx_valid <= sync2;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Data path
    ////////////////////////////////////////

    always_ff @(posedge clock_in) begin
        if (receiving && timer_mid) begin
            if (bit_index != 8'd0 && bit_index != 8'(board_pkg::FRAME_BITS - 1)) begin
                rx_shift <= {sync2, rx_shift[board_pkg::BOARD_BITS-1:1]};
            end
            // Hold the board for the controller
            if (bit_index == 8'(board_pkg::FRAME_BITS - 1) && sync2) begin
                rx_board <= rx_shift;
            end
        end
    end

endmodule

// File: hw/board_link_tx.sv
`timescale 1ns/1ps

module board_link_tx (
    input  logic              clock_in,
    input  logic              reset_in,
    input  logic              send,
    input  board_pkg::board_t board,
    output logic              line,
    output logic              busy
);

    ////////////////////////////////////////
    // Frame timing
    ////////////////////////////////////////

    logic       timer_start;
    logic       timer_active;
    logic [7:0] bit_index;

    // Snapshot of the board for the running frame
    board_pkg::board_t tx_data;

    // Requests during a frame are dropped
    assign timer_start = send && !timer_active;
    assign busy = timer_active;

    bit_timer tx_timer (
        .clock_in  (clock_in),
        .reset_in  (reset_in),
        .start     (timer_start),
        .active    (timer_active),
        .mid       (),
        .bit_end   (),
        .bit_index (bit_index)
    );

    // Latch the board with the start request
    always_ff @(posedge clock_in) begin
        if (timer_start) begin
            tx_data <= board;
        end
    end

    ////////////////////////////////////////
    // Line value by bit position
    ////////////////////////////////////////

    always_comb begin
        if (!timer_active) begin
            // Idle line is high
            line = 1'b1;
        end else if (bit_index == 8'd0) begin
            line = 1'b0;
        end else if (bit_index == 8'(board_pkg::FRAME_BITS - 1)) begin
            line = 1'b1;
        end else begin
            // Data bits go out low bit first
            line = tx_data[bit_index - 8'd1];
        end
    end

endmodule

// File: hw/board_pkg.sv
package board_pkg;

    ////////////////////////////////////////
    // Board geometry and serial timing
    ////////////////////////////////////////

    // 9x9 cells, 2 bits each
    localparam int BOARD_CELLS = 81;
    localparam int BOARD_BITS = 162;
    // Start bit, 162 data bits, stop bit
    localparam int FRAME_BITS = 164;
    // Clocks per serial bit
    localparam int BIT_CYCLES = 8;
    // Stable cycles before the button level is taken
    localparam int DEBOUNCE_CYCLES = 16;

    // Scalar types
    typedef logic [1:0] cell_t;
    typedef logic [BOARD_BITS-1:0] board_t;
    typedef logic [6:0] cell_index_t;
    typedef logic [15:0] wb_data_t;
    typedef logic [7:0] wb_addr_t;

    // Cell codes
    localparam cell_t CELL_EMPTY = 2'd0;
    localparam cell_t CELL_X = 2'd1;
    localparam cell_t CELL_O = 2'd2;

    // Special bus addresses
    localparam wb_addr_t ADR_CLEAR = 8'hFE;
    localparam wb_addr_t ADR_STATUS = 8'hFF;

    ////////////////////////////////////////
    // Wishbone classic request and response
    ////////////////////////////////////////

    // Host side
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_data_t dat_w;
    } wb_req_t;

    // Slave side
    typedef struct packed {
        logic     ack;
        wb_data_t dat_r;
    } wb_rsp_t;

    // Game controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CHECK,
        ST_PLACE,
        ST_LOAD,
        ST_CLEAR,
        ST_ACK
    } game_state_t;

endpackage

// File: hw/board_top.sv
`timescale 1ns/1ps

module board_top (
    input  logic               clock_in,
    input  logic               reset_in,
    input  board_pkg::wb_req_t wb_req,
    output board_pkg::wb_rsp_t wb_rsp,
    input  logic               button,
    input  logic               follow,
    input  logic               link_rx,
    output logic               link_tx
);

    // Press pulse from the button filter
    logic btn_rise;

    // Live board from the controller
    board_pkg::board_t board;

    // Frame from the peer
    logic              rx_valid;
    board_pkg::board_t rx_board;

    ////////////////////////////////////////
    // Button and game controller
    ////////////////////////////////////////

    debounce btn_db (
        .clock_in (clock_in),
        .reset_in (reset_in),
        .noisy    (button),
        .clean    (),
        .rise     (btn_rise)
    );

    game_fsm game (
        .clock_in (clock_in),
        .reset_in (reset_in),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .follow   (follow),
        .rx_valid (rx_valid),
        .rx_board (rx_board),
        .board    (board)
    );

    ////////////////////////////////////////
    // Serial link
    ////////////////////////////////////////

    // Snapshot goes out on each press
    board_link_tx link_out (
        .clock_in (clock_in),
        .reset_in (reset_in),
        .send     (btn_rise),
        .board    (board),
        .line     (link_tx),
        .busy     ()
    );

    board_link_rx link_in (
        .clock_in (clock_in),
        .reset_in (reset_in),
        .line     (link_rx),
        .rx_valid (rx_valid),
        .rx_board (rx_board)
    );

endmodule

// File: hw/debounce.sv
`timescale 1ns/1ps

module debounce (
    input  logic clock_in,
    input  logic reset_in,
    input  logic noisy,
    output logic clean,
    output logic rise
);

    // Last raw sample of the button
    logic sample;
    // Cycles the sample has stayed the same
    logic [$clog2(board_pkg::DEBOUNCE_CYCLES+1)-1:0] stable_cnt;
    // Clean level one cycle ago
    logic clean_prev;

    always_ff @(posedge clock_in) begin
        if (reset_in) begin
            sample <= 1'b0;
            stable_cnt <= '0;
            clean <= 1'b0;
            clean_prev <= 1'b0;
        end else begin
            clean_prev <= clean;
            // Any change restarts the stability window
            if (noisy != sample) begin
                sample <= noisy;
                stable_cnt <= '0;
            end else if (stable_cnt == board_pkg::DEBOUNCE_CYCLES) begin
                clean <= sample;
            end else begin
                stable_cnt <= stable_cnt + 1'b1;
            end
        end
    end

    // One pulse per press
    assign rise = clean && !clean_prev;

endmodule

// File: hw/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
    input  logic                 clock_in,
    input  logic                 reset_in,
    input  board_pkg::wb_req_t   wb_req,
    output board_pkg::wb_rsp_t   wb_rsp,
    input  logic                 follow,
    input  logic                 rx_valid,
    input  board_pkg::board_t    rx_board,
    output board_pkg::board_t    board
);

    board_pkg::game_state_t state;

    // Current player, 0 means X to move
    logic       player;
    // Saturating count of rejected writes
    logic [7:0] illegal_cnt;
    // Received frame waiting to be served
    logic       rx_pend;

    // Latched request
    board_pkg::wb_addr_t req_adr;
    logic                req_we;
    board_pkg::wb_data_t rdata;

    board_pkg::cell_index_t req_idx;
    board_pkg::cell_t       req_cell;
    logic                   req_in_board;
    logic                   bus_start;

    assign bus_start = wb_req.cyc && wb_req.stb;
    assign req_idx = board_pkg::cell_index_t'(req_adr[6:0]);
    assign req_in_board = req_adr < board_pkg::wb_addr_t'(board_pkg::BOARD_CELLS);
    assign req_cell = board[2*req_idx +: 2];

    // Ack straight from the state, one cycle long
    always_comb begin
        wb_rsp.ack = (state == board_pkg::ST_ACK);
        wb_rsp.dat_r = rdata;
    end

    ////////////////////////////////////////
    // Controller
    ////////////////////////////////////////

    always_ff @(posedge clock_in) begin
        if (reset_in) begin
            state <= board_pkg::ST_IDLE;
            player <= 1'b0;
            illegal_cnt <= '0;
            rx_pend <= 1'b0;
            board <= '0;
        end else begin
            case (state)
                board_pkg::ST_IDLE: begin
                    // Link load goes before the bus
                    if (rx_pend) begin
                        if (follow) begin
                            state <= board_pkg::ST_LOAD;
                        end else begin
                            rx_pend <= 1'b0;
                        end
                    end else if (bus_start) begin
                        if (wb_req.we && wb_req.adr == board_pkg::ADR_CLEAR) begin
                            state <= board_pkg::ST_CLEAR;
                        end else begin
                            state <= board_pkg::ST_CHECK;
                        end
                    end
                end
                board_pkg::ST_CHECK: begin
                    if (req_we && req_in_board && req_cell == board_pkg::CELL_EMPTY) begin
                        state <= board_pkg::ST_PLACE;
                    end else begin
                        // Bad address or occupied cell
                        if (req_we && illegal_cnt != 8'hFF) begin
                            illegal_cnt <= illegal_cnt + 8'd1;
                        end
                        state <= board_pkg::ST_ACK;
                    end
                end
                board_pkg::ST_PLACE: begin
                    board[2*req_idx +: 2] <= player ? board_pkg::CELL_O : board_pkg::CELL_X;
                    player <= !player;
                    state <= board_pkg::ST_ACK;
                end
                board_pkg::ST_LOAD: begin
                    board <= rx_board;
                    rx_pend <= 1'b0;
                    state <= board_pkg::ST_IDLE;
                end
                board_pkg::ST_CLEAR: begin
                    // Count of illegal moves survives
                    board <= '0;
                    player <= 1'b0;
                    state <= board_pkg::ST_ACK;
                end
                default: begin
                    state <= board_pkg::ST_IDLE;
                end
            endcase
            // New frame wins over a clear in the same cycle
            if (rx_valid) begin
                rx_pend <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Request capture and read data
    ////////////////////////////////////////

    always_ff @(posedge clock_in) begin
        if (state == board_pkg::ST_IDLE && bus_start) begin
            req_adr <= wb_req.adr;
            req_we <= wb_req.we;
            rdata <= '0;
        end else if (state == board_pkg::ST_CHECK && !req_we) begin
            if (req_in_board) begin
                rdata <= board_pkg::wb_data_t'(req_cell);
            end else if (req_adr == board_pkg::ADR_STATUS) begin
                rdata <= {illegal_cnt, 7'd0, player};
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the board testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f build.f \
    --top-module board_tb \
    -o board_sim

./obj_dir/board_sim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    exit 0
else
    exit 1
fi
